//--- files.f
+incdir+rtl
rtl/rvPkg.sv
rtl/rvDecoder.sv
rtl/rvRegFile.sv
rtl/rvAlu.sv
rtl/rvProgramCounter.sv
rtl/rvCore.sv
sim/rvCore_sva.sv
sim/rvCoreTb.sv

//--- Makefile
# Verilator build and run of the RV32I core testbench.

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module rvCoreTb -o simv
	./obj_dir/simv +verilator+error+limit+100 | tee sim.log
	@if grep -q "^sim passed$$" sim.log; then \
		echo "test: pass"; \
	else \
		echo "test: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- sim/rvCoreTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvCoreTb import rvPkg::*; ();

    localparam int RunLength = 2000;
    localparam int TimeoutCycles = RunLength + RunLength / 2;
    // x31 holds this data pointer, x30 holds the program base.
    localparam int DataPointer = 128;

    logic                clk = 1'b0;
    logic                rst;
    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] instrAddr;
    memReq_s             dataReq;
    logic [`RV_XLEN-1:0] rdata;

    logic [31:0] prog [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] mMem [0:63];
    logic [31:0] mRegs [0:31];
    logic [31:0] mPc;
    logic [31:0] rngState = 32'h4347141f;
    int          cycles = 0;
    int          retired = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;

    always #50 clk = ~clk;

    rvCore u_dut (
        .clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
        .dataReq(dataReq), .rdata(rdata)
    );

    // memories answer within the cycle; the program sits at 0x800.
    assign instr = prog[instrAddr[9:2]];
    assign rdata = dmem[dataReq.addr[7:2]];

    always @(posedge clk) begin
        if (dataReq.write) begin
            dmem[dataReq.addr[7:2]] <= dataReq.wdata;
        end
    end

    always @(posedge clk) cycles <= cycles + 1;

    // ********************
    // random numbers and encoders.
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic int pick(input int n);
        return int'(nextRandom() % 32'(n));
    endfunction

    function automatic logic [31:0] fillWord(input int idx);
        logic [31:0] byteAddr;
        byteAddr = 32'(idx) << 2;
        return (byteAddr * 32'h9E3779B1) ^ 32'hC0DE0000;
    endfunction

    function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [6:0] op, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] branchWord(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] upperWord(input logic [6:0] op, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jalWord(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    // ********************
    // program generator.
    function automatic logic [31:0] randomInstr(input int slot);
        int          kind;
        int          tgt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] off;
        rd = 5'(pick(30));
        rs1 = 5'(pick(32));
        rs2 = 5'(pick(32));
        f3 = 3'(pick(8));
        kind = pick(12);
        tgt = pick(255);
        if (tgt == slot) begin
            tgt = (slot + 1) % 255;
        end
        off = 32'((tgt - slot) * 4);
        case (kind)
            0, 1, 2: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && pick(2) == 1) ? 7'h20 : 7'h00;
                return rTypeWord(f7, rs2, rs1, f3, rd);
            end
            3, 4: begin
                imm = 12'(nextRandom());
                if (f3 == 3'b001) begin
                    imm = {7'h00, imm[4:0]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, imm[10], 5'b00000, imm[4:0]};
                end
                return iTypeWord(`RV_OP_IMM, f3, rd, rs1, imm);
            end
            5: begin
                if (pick(2) == 0) begin
                    return upperWord(`RV_OP_LUI, rd, 20'(nextRandom()));
                end
                return upperWord(`RV_OP_AUIPC, rd, 20'(nextRandom()));
            end
            6: begin
                case (pick(6))
                    0:       f3 = 3'b000;
                    1:       f3 = 3'b001;
                    2:       f3 = 3'b100;
                    3:       f3 = 3'b101;
                    4:       f3 = 3'b110;
                    default: f3 = 3'b111;
                endcase
                return branchWord(f3, rs1, rs2, off[12:0]);
            end
            7:       return jalWord(rd, off[20:0]);
            8:       return iTypeWord(`RV_OP_JALR, 3'b000, rd, 5'd30, 12'(tgt * 4));
            9: begin
                if (pick(2) == 0) begin
                    return iTypeWord(`RV_OP_LOAD, 3'b010, rd, 5'd0, 12'(pick(64) * 4));
                end
                return iTypeWord(`RV_OP_LOAD, 3'b010, rd, 5'd31,
                                 12'(pick(64) * 4 - DataPointer));
            end
            default: begin
                if (pick(2) == 0) begin
                    return storeWord(rs2, 5'd0, 12'(pick(64) * 4));
                end
                return storeWord(rs2, 5'd31, 12'(pick(64) * 4 - DataPointer));
            end
        endcase
    endfunction

    task automatic genProgram();
        prog[0] = iTypeWord(`RV_OP_IMM, 3'b000, 5'd30, 5'd0, 12'd1);
        prog[1] = iTypeWord(`RV_OP_IMM, 3'b001, 5'd30, 5'd30, 12'd11);
        prog[2] = iTypeWord(`RV_OP_IMM, 3'b000, 5'd31, 5'd0, 12'(DataPointer));
        for (int slot = 3; slot < 255; slot++) begin
            prog[slot] = randomInstr(slot);
        end
        // last slot loops back past the setup words.
        prog[255] = jalWord(5'd0, 21'((3 - 255) * 4));
    endtask

    // ********************
    // reference model.
    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            // arithmetic shift fills the vacated top bits with the sign.
            3'b101:  return alt ? (a >> b[4:0]) | (~(32'hFFFFFFFF >> b[4:0]) & {32{a[31]}})
                                : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("FAIL %0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("FAIL %0t %s got=%b expected=%b", $time, name, got, exp);
        end
    endtask

    task automatic retireInstr();
        logic [31:0] ins;
        logic [6:0]  op;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] nextPc;
        logic        wr;
        ins = prog[mPc[9:2]];
        op = ins[6:0];
        rd = ins[11:7];
        f3 = ins[14:12];
        a = mRegs[ins[19:15]];
        b = mRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'b0};
        immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        addr = a + ((op == `RV_OP_STORE) ? immS : immI);

        checkWord("instrAddr", instrAddr, mPc);
        checkBit("dataReq.read", dataReq.read, op == `RV_OP_LOAD);
        checkBit("dataReq.write", dataReq.write, op == `RV_OP_STORE);
        if (op == `RV_OP_LOAD || op == `RV_OP_STORE) begin
            checkWord("dataReq.addr", dataReq.addr, addr);
        end
        if (op == `RV_OP_STORE) begin
            checkWord("dataReq.wdata", dataReq.wdata, b);
        end
        if (dataReq.read || dataReq.write) begin
            assert (dataReq.addr[1:0] == 2'b00 && dataReq.addr < 32'd256) else begin
                otherErrors++;
                $display("data access at %0t falls outside the aligned data region", $time);
            end
        end

        nextPc = mPc + 4;
        wr = 1'b1;
        case (op)
            `RV_OP_LUI:    res = immU;
            `RV_OP_AUIPC:  res = mPc + immU;
            `RV_OP_JAL: begin
                res = mPc + 4;
                nextPc = mPc + immJ;
            end
            `RV_OP_JALR: begin
                res = mPc + 4;
                nextPc = (a + immI) & ~32'd1;
            end
            `RV_OP_BRANCH: begin
                res = '0;
                wr = 1'b0;
                if (branchTaken(f3, a, b)) begin
                    nextPc = mPc + immB;
                end
            end
            `RV_OP_LOAD:   res = mMem[addr[7:2]];
            `RV_OP_STORE: begin
                res = '0;
                wr = 1'b0;
                mMem[addr[7:2]] = b;
            end
            `RV_OP_IMM:    res = aluModel(f3, f3 == 3'b101 && ins[30], a, immI);
            default:       res = aluModel(f3, ins[30], a, b);
        endcase
        if (wr && rd != 5'd0) begin
            mRegs[rd] = res;
        end
        mPc = nextPc;
    endtask

    // compare on the falling edge, where all outputs have settled.
    always @(negedge clk) begin
        if (rst) begin
            checkWord("instrAddr", instrAddr, `RV_RESET_PC);
            checkBit("dataReq.read", dataReq.read, 1'b0);
            checkBit("dataReq.write", dataReq.write, 1'b0);
        end else if (retired < RunLength) begin
            retireInstr();
            retired++;
        end
    end

    // ********************
    // main sequence.
    initial begin
        rst = 1'b1;
        mPc = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
            mMem[i] = fillWord(i);
        end
        genProgram();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (retired < RunLength && cycles < TimeoutCycles) begin
            @(posedge clk);
        end
        if (retired < RunLength) begin
            otherErrors++;
            $display("timeout after %0d cycles with %0d instructions retired", cycles, retired);
        end
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 valueErrors, otherErrors, u_dut.coreProps.violations);
        if (valueErrors == 0 && otherErrors == 0 && u_dut.coreProps.violations == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/rvCore_sva.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvCoreSva import rvPkg::*; (
    input logic                clk,
    input logic                rst,
    input logic [`RV_XLEN-1:0] instrAddr,
    input memReq_s             dataReq
);

    int violations = 0;

    // ********************
    // data port protocol.
    noDualAccess: assert property (@(posedge clk) disable iff (rst)
        !(dataReq.read && dataReq.write))
        else begin
            violations++;
            $error("read and write strobes are high in the same cycle");
        end

    alignedDataAddr: assert property (@(posedge clk) disable iff (rst)
        (dataReq.read || dataReq.write) |-> dataReq.addr[1:0] == 2'b00)
        else begin
            violations++;
            $error("data address is not word aligned during an access");
        end

    // fetch address, also checked during reset.
    alignedFetchAddr: assert property (@(posedge clk)
        instrAddr[1:0] == 2'b00)
        else begin
            violations++;
            $error("fetch address is not word aligned");
        end

endmodule

bind rvCore rvCoreSva coreProps (
    .clk(clk),
    .rst(rst),
    .instrAddr(instrAddr),
    .dataReq(dataReq)
);

`default_nettype wire

//--- rtl/rvCore.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvCore import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] instrAddr,
    output memReq_s             dataReq,
    input  logic [`RV_XLEN-1:0] rdata
);

    decoded_s            dec;
    logic [`RV_XLEN-1:0] rs1Data;
    logic [`RV_XLEN-1:0] rs2Data;
    logic [`RV_XLEN-1:0] opA;
    logic [`RV_XLEN-1:0] opB;
    logic [`RV_XLEN-1:0] aluResult;
    logic [`RV_XLEN-1:0] wbData;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pcPlus4;
    logic                regWrite;

    // ********************
    // fetch and decode.
    assign instrAddr = rst ? `RV_RESET_PC : pc;

    rvDecoder decoder (.instr(instr), .dec(dec));

    rvRegFile regFile (
        .clk(clk), .rst(rst),
        .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .we(regWrite), .wdata(wbData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    // ********************
    // execute.
    always_comb begin
        case (dec.opASel)
            OPA_PC:   opA = pc;
            OPA_ZERO: opA = '0;
            default:  opA = rs1Data;
        endcase
    end

    assign opB = (dec.opBSel == OPB_IMM) ? dec.imm : rs2Data;

    rvAlu alu (.op(dec.aluOp), .a(opA), .b(opB), .result(aluResult));

    // jal and jalr both take the alu sum as target.
    rvProgramCounter pcUnit (
        .clk(clk), .rst(rst),
        .branch(dec.branch), .jump(dec.jump | dec.jumpReg),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .imm(dec.imm), .target(aluResult),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    // ********************
    // memory and write-back.
    assign dataReq.read = dec.memRead && !rst;
    assign dataReq.write = dec.memWrite && !rst;
    assign dataReq.addr = aluResult;
    assign dataReq.wdata = rs2Data;

    always_comb begin
        case (dec.wbSel)
            WB_MEM:  wbData = rdata;
            WB_PC4:  wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    assign regWrite = dec.regWrite && !rst;

endmodule

`default_nettype wire

//--- rtl/rvProgramCounter.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvProgramCounter import rvPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  branchKind_e         branch,
    input  logic                jump,
    input  logic [`RV_XLEN-1:0] rs1Data,
    input  logic [`RV_XLEN-1:0] rs2Data,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] target,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] pcPlus4
);

    logic                taken;
    logic [`RV_XLEN-1:0] nextPc;

    // ********************
    // branch condition.
    always_comb begin
        case (branch)
            BR_EQ:   taken = rs1Data == rs2Data;
            BR_NE:   taken = rs1Data != rs2Data;
            BR_LT:   taken = $signed(rs1Data) < $signed(rs2Data);
            BR_GE:   taken = $signed(rs1Data) >= $signed(rs2Data);
            BR_LTU:  taken = rs1Data < rs2Data;
            BR_GEU:  taken = rs1Data >= rs2Data;
            default: taken = 1'b0;
        endcase
    end

    // ********************
    // next pc.
    assign pcPlus4 = pc + `RV_XLEN'(4);

    always_comb begin
        if (jump) begin
            nextPc = {target[`RV_XLEN-1:1], 1'b0};
        end else if (taken) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rvAlu.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvAlu import rvPkg::*; (
    input  aluOp_e              op,
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt = b[4:0];
    assign lessSigned = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            // compares give 0 or 1.
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lessSigned};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lessUnsigned};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rvRegFile.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvRegFile (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`RV_REG_IDX_W-1:0] rs1,
    input  logic [`RV_REG_IDX_W-1:0] rs2,
    input  logic [`RV_REG_IDX_W-1:0] rd,
    input  logic                     we,
    input  logic [`RV_XLEN-1:0]      wdata,
    output logic [`RV_XLEN-1:0]      rs1Data,
    output logic [`RV_XLEN-1:0]      rs2Data
);

    // x0 has no storage.
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- rtl/rvDecoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_config.svh"

module rvDecoder import rvPkg::*; (
    input  instrWord_u instr,
    output decoded_s   dec
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       immShiftBad;
    logic       regFunctBad;

    // alt selects SUB over ADD and SRA over SRL.
    function automatic aluOp_e aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct7 = instr.r.funct7;
    assign funct3 = instr.r.funct3;

    assign immShiftBad = (funct3 == 3'b001 && funct7 != 7'b0000000) ||
                         (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000);
    assign regFunctBad = funct7 != 7'b0000000 &&
                         !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        dec = '0;
        dec.rs1 = instr.r.rs1;
        dec.rs2 = instr.r.rs2;
        dec.rd = instr.r.rd;
        dec.aluOp = ALU_ADD;
        dec.opASel = OPA_RS1;
        dec.opBSel = OPB_IMM;
        dec.wbSel = WB_ALU;
        dec.branch = BR_NONE;
        dec.imm = {{20{instr.i.imm[11]}}, instr.i.imm};
        case (instr.r.opcode)
            `RV_OP_LUI: begin
                dec.imm = {instr.u.imm, 12'b0};
                dec.opASel = OPA_ZERO;
                dec.regWrite = 1'b1;
            end
            `RV_OP_AUIPC: begin
                dec.imm = {instr.u.imm, 12'b0};
                dec.opASel = OPA_PC;
                dec.regWrite = 1'b1;
            end
            `RV_OP_JAL: begin
                dec.imm = {{12{instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                           instr.j.imm10to1, 1'b0};
                dec.opASel = OPA_PC;
                dec.wbSel = WB_PC4;
                dec.regWrite = 1'b1;
                dec.jump = 1'b1;
            end
            `RV_OP_JALR: begin
                dec.wbSel = WB_PC4;
                dec.regWrite = 1'b1;
                dec.jumpReg = 1'b1;
                dec.illegal = funct3 != 3'b000;
            end
            `RV_OP_BRANCH: begin
                dec.imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                           instr.b.imm4to1, 1'b0};
                case (funct3)
                    3'b000:  dec.branch = BR_EQ;
                    3'b001:  dec.branch = BR_NE;
                    3'b100:  dec.branch = BR_LT;
                    3'b101:  dec.branch = BR_GE;
                    3'b110:  dec.branch = BR_LTU;
                    3'b111:  dec.branch = BR_GEU;
                    default: dec.illegal = 1'b1;
                endcase
            end
            `RV_OP_LOAD: begin
                dec.wbSel = WB_MEM;
                dec.regWrite = 1'b1;
                dec.memRead = 1'b1;
                dec.illegal = funct3 != 3'b010;
            end
            `RV_OP_STORE: begin
                dec.imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
                dec.memWrite = 1'b1;
                dec.illegal = funct3 != 3'b010;
            end
            `RV_OP_IMM: begin
                // only the right shift reads funct7 as a variant bit.
                dec.aluOp = aluFromFunct3(funct3, funct3 == 3'b101 && funct7[5]);
                dec.regWrite = 1'b1;
                dec.illegal = immShiftBad;
            end
            `RV_OP_REG: begin
                dec.opBSel = OPB_RS2;
                dec.aluOp = aluFromFunct3(funct3, funct7[5]);
                dec.regWrite = 1'b1;
                dec.illegal = regFunctBad;
            end
            default: dec.illegal = 1'b1;
        endcase
        // an illegal word retires as a plain pc+4 no-op.
        if (dec.illegal) begin
            dec.regWrite = 1'b0;
            dec.memRead = 1'b0;
            dec.memWrite = 1'b0;
            dec.branch = BR_NONE;
            dec.jump = 1'b0;
            dec.jumpReg = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rvPkg.sv
`default_nettype none
`include "rv_config.svh"

package rvPkg;

    // ********************
    // instruction formats, all 32 bits wide.
    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`RV_REG_IDX_W-1:0]   rs2;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0]                imm;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } iType_s;

    typedef struct packed {
        logic [6:0]                 immHi;
        logic [`RV_REG_IDX_W-1:0]   rs2;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 immLo;
        logic [6:0]                 opcode;
    } sType_s;

    typedef struct packed {
        logic                       imm12;
        logic [5:0]                 imm10to5;
        logic [`RV_REG_IDX_W-1:0]   rs2;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [3:0]                 imm4to1;
        logic                       imm11;
        logic [6:0]                 opcode;
    } bType_s;

    typedef struct packed {
        logic [19:0]                imm;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } uType_s;

    typedef struct packed {
        logic                       imm20;
        logic [9:0]                 imm10to1;
        logic                       imm11;
        logic [7:0]                 imm19to12;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } jType_s;

    typedef union packed {
        rType_s r;
        iType_s i;
        sType_s s;
        bType_s b;
        uType_s u;
        jType_s j;
    } instrWord_u;

    // ********************
    // control encodings.
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR
    } aluOp_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branchKind_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} opASel_e;
    typedef enum logic {OPB_RS2, OPB_IMM} opBSel_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wbSel_e;

    typedef struct packed {
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [`RV_REG_IDX_W-1:0]   rs2;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [`RV_XLEN-1:0]        imm;
        aluOp_e                     aluOp;
        opASel_e                    opASel;
        opBSel_e                    opBSel;
        wbSel_e                     wbSel;
        logic                       regWrite;
        logic                       memRead;
        logic                       memWrite;
        branchKind_e                branch;
        logic                       jump;
        logic                       jumpReg;
        logic                       illegal;
    } decoded_s;

    // word-wide data port request.
    typedef struct packed {
        logic                       read;
        logic                       write;
        logic [`RV_XLEN-1:0]        addr;
        logic [`RV_XLEN-1:0]        wdata;
    } memReq_s;

endpackage

`default_nettype wire

//--- rtl/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath and register file sizes.
`define RV_XLEN         32
`define RV_REG_COUNT    32
`define RV_REG_IDX_W    5

// first fetch address once reset is released.
`define RV_RESET_PC     32'd2048

// ********************
// major opcodes, bits 6:0 of the instruction.
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011

`endif
